/* Makefile */
TOOL       ?= verilator
TOP        ?= vliwCore_tb
RTL_TOP    ?= vliwCore
FILELIST   ?= vliwCore.f
BUILD_DIR  ?= obj_dir
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* hw/bundleDecoder.sv */
// vliw bundle decoder
`include "vliw_defines.svh"

module bundleDecoder
(
	input  logic             valid,
	input  vliwPkg::instr_t  instr,
	input  vliwPkg::instrC_t instrC,
	// main slot
	output vliwPkg::regIdx_t rs1,
	output vliwPkg::regIdx_t rs2,
	output vliwPkg::regIdx_t rd,
	output vliwPkg::aluOp_e  aluOp,
	output logic             useImm,
	output vliwPkg::word_t   imm,
	output logic             writeMain,
	// compressed slot
	output vliwPkg::regIdx_t rsC,
	output vliwPkg::regIdx_t rdC,
	output vliwPkg::cSrc_e   cSrc,
	output vliwPkg::word_t   immC,
	output logic             writeC
);
	import vliwPkg::*;

	// main slot fields
	logic [6:0] opcode;
	logic [2:0] funct3;
	// compressed quadrant
	logic [1:0] quadC;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign quadC  = instrC[1:0];

	////////////////////
	// register indices
	////////////////////

	// standard 32-bit field positions
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd  = instr[11:7];

	// c.mv source in 6:2, destination in 11:7 for both forms
	assign rsC = instrC[6:2];
	assign rdC = instrC[11:7];

	////////////////////
	// main slot control
	////////////////////

	always_comb
	begin
		// default is a no-write
		aluOp     = aluAdd;
		useImm    = 1'b0;
		imm       = '0;
		writeMain = 1'b0;
		if (opcode == `VLIW_OP_REG)
		begin
			// add, both operands from registers
			writeMain = valid;
		end
		else if ((opcode == `VLIW_OP_IMM) && (funct3 == `VLIW_F3_ANDI))
		begin
			// andi, sign extended 12-bit immediate
			aluOp     = aluAnd;
			useImm    = 1'b1;
			imm       = {{(`VLIW_XLEN-12){instr[31]}}, instr[31:20]};
			writeMain = valid;
		end
		else if ((opcode == `VLIW_OP_IMM) && (funct3 == `VLIW_F3_SRAI))
		begin
			// srai, zero extended shamt
			aluOp     = aluSra;
			useImm    = 1'b1;
			imm       = {{(`VLIW_XLEN-5){1'b0}}, instr[24:20]};
			writeMain = valid;
		end
		// sh, bge, jalr and zero word drop through here
	end

	////////////////////
	// compressed slot control
	////////////////////

	// c.li immediate, bit 12 is the sign
	assign immC = {{(`VLIW_XLEN-6){instrC[12]}}, instrC[12], instrC[6:2]};

	always_comb
	begin
		cSrc   = cSrcMove;
		writeC = 1'b0;
		case (quadC)
			`VLIW_QUAD_MV:
			begin
				writeC = valid;
			end
			`VLIW_QUAD_LI:
			begin
				cSrc   = cSrcImm;
				writeC = valid;
			end
			// c.lw quadrant and 32-bit patterns
			default:
			begin
				writeC = 1'b0;
			end
		endcase
	end

endmodule

/* hw/executeSlots.sv */
// vliw execute and result register
`include "vliw_defines.svh"

module executeSlots
(
	input  logic             clk,
	input  logic             reset,
	input  logic             valid,
	// main slot controls
	input  vliwPkg::aluOp_e  aluOp,
	input  logic             useImm,
	input  vliwPkg::word_t   imm,
	input  vliwPkg::regIdx_t rd,
	input  logic             writeMain,
	// compressed slot controls
	input  vliwPkg::cSrc_e   cSrc,
	input  vliwPkg::word_t   immC,
	input  vliwPkg::regIdx_t rdC,
	input  logic             writeC,
	// resolved operands
	input  vliwPkg::word_t   opA,
	input  vliwPkg::word_t   opB,
	input  vliwPkg::word_t   opC,
	// result register
	output logic             resultValid,
	output logic             wbWrite,
	output vliwPkg::regIdx_t wbReg,
	output vliwPkg::word_t   wbData,
	output logic             wbWriteC,
	output vliwPkg::regIdx_t wbRegC,
	output vliwPkg::word_t   wbDataC
);
	import vliwPkg::*;

	// shift amount width is log2 of xlen
	localparam int ShamtW = $clog2(`VLIW_XLEN);

	word_t aluB;
	word_t aluResult;
	word_t cResult;

	////////////////////
	// main alu
	////////////////////

	assign aluB = useImm ? imm : opB;

	always_comb
	begin
		case (aluOp)
			aluAdd: aluResult = opA + aluB;
			aluAnd: aluResult = opA & aluB;
			// sign fills from the top
			aluSra: aluResult = word_t'($signed(opA) >>> aluB[ShamtW-1:0]);
			default: aluResult = opA + aluB;
		endcase
	end

	// c.mv passes the register and c.li the immediate
	assign cResult = (cSrc == cSrcImm) ? immC : opC;

	////////////////////
	// result register
	////////////////////

	// enables arrive already gated by valid
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultValid <= 1'b0;
			wbWrite     <= 1'b0;
			wbReg       <= '0;
			wbData      <= '0;
			wbWriteC    <= 1'b0;
			wbRegC      <= '0;
			wbDataC     <= '0;
		end
		else
		begin
			resultValid <= valid;
			wbWrite     <= writeMain;
			wbReg       <= rd;
			wbData      <= aluResult;
			wbWriteC    <= writeC;
			wbRegC      <= rdC;
			wbDataC     <= cResult;
		end
	end

	// an idle slot in the stream never writes
	idleNoWrite: assert property (@(posedge clk) disable iff (reset)
		!resultValid |-> !wbWrite && !wbWriteC);

endmodule

/* hw/operandForward.sv */
// operand bypass from result register
module operandForward
(
	// source indices of the decoding bundle
	input  vliwPkg::regIdx_t rs1,
	input  vliwPkg::regIdx_t rs2,
	input  vliwPkg::regIdx_t rsC,
	// register file values
	input  vliwPkg::word_t   regA,
	input  vliwPkg::word_t   regB,
	input  vliwPkg::word_t   regC,
	// previous bundle, main slot
	input  logic             fwdWrite,
	input  vliwPkg::regIdx_t fwdReg,
	input  vliwPkg::word_t   fwdData,
	// previous bundle, compressed slot
	input  logic             fwdWriteC,
	input  vliwPkg::regIdx_t fwdRegC,
	input  vliwPkg::word_t   fwdDataC,
	// resolved operands
	output vliwPkg::word_t   opA,
	output vliwPkg::word_t   opB,
	output vliwPkg::word_t   opC
);
	import vliwPkg::*;

	// one source through the bypass mux
	// compressed hit checked first, same as the write priority
	function automatic word_t resolve(regIdx_t src, word_t regVal);
		word_t val;
		if (fwdWriteC && (fwdRegC == src))
		begin
			val = fwdDataC;
		end
		else if (fwdWrite && (fwdReg == src))
		begin
			val = fwdData;
		end
		else
		begin
			val = regVal;
		end
		return val;
	endfunction

	////////////////////
	// bypass muxes
	////////////////////

	// older bundles are already in the register file
	always_comb
	begin
		opA = resolve(rs1, regA);
		opB = resolve(rs2, regB);
		opC = resolve(rsC, regC);
	end

endmodule

/* hw/registerFile.sv */
// shared vliw register file
`include "vliw_defines.svh"

module registerFile
(
	input  logic            clk,
	input  logic            reset,
	// main slot write port
	input  logic            wrEn,
	input  vliwPkg::regIdx_t wrIdx,
	input  vliwPkg::word_t   wrData,
	// compressed slot write port
	input  logic            wrEnC,
	input  vliwPkg::regIdx_t wrIdxC,
	input  vliwPkg::word_t   wrDataC,
	// read indices
	input  vliwPkg::regIdx_t rdIdxA,
	input  vliwPkg::regIdx_t rdIdxB,
	input  vliwPkg::regIdx_t rdIdxCA,
	// read data
	output vliwPkg::word_t   rdDataA,
	output vliwPkg::word_t   rdDataB,
	output vliwPkg::word_t   rdDataCA
);
	import vliwPkg::*;

	// storage, r0 is a normal register
	word_t mem [`VLIW_NUM_REGS];

	// main port loses to compressed port on same index
	logic mainWins;

	assign mainWins = wrEn && !(wrEnC && (wrIdxC == wrIdx));

	////////////////////
	// write ports
	////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `VLIW_NUM_REGS; i++)
			begin
				mem[i] <= '0;
			end
		end
		else
		begin
			if (mainWins)
			begin
				mem[wrIdx] <= wrData;
			end
			// compressed slot always lands
			if (wrEnC)
			begin
				mem[wrIdxC] <= wrDataC;
			end
		end
	end

	////////////////////
	// read ports
	////////////////////

	// plain async reads, bypass is done in operandForward
	assign rdDataA  = mem[rdIdxA];
	assign rdDataB  = mem[rdIdxB];
	assign rdDataCA = mem[rdIdxCA];

	// main write survives one untouched cycle
	holdAfterWrite: assert property (@(posedge clk) disable iff (reset)
		$past(mainWins) && !(wrEn && (wrIdx == $past(wrIdx)))
			&& !(wrEnC && (wrIdxC == $past(wrIdx)))
		|=> mem[$past(wrIdx, 2)] == $past(wrData, 2));

endmodule

/* hw/vliwCore.sv */
// two-slot vliw execution core
module vliwCore
(
	input  logic             clk,
	input  logic             reset,
	// bundle stream, no back-pressure
	input  logic             bundleValid,
	input  vliwPkg::instr_t  instr,
	input  vliwPkg::instrC_t instrC,
	// writeback
	output logic             resultValid,
	output logic             wbWrite,
	output vliwPkg::regIdx_t wbReg,
	output vliwPkg::word_t   wbData,
	output logic             wbWriteC,
	output vliwPkg::regIdx_t wbRegC,
	output vliwPkg::word_t   wbDataC
);
	import vliwPkg::*;

	// bundle register
	logic    validQ;
	instr_t  instrQ;
	instrC_t instrCQ;

	// decode outputs
	regIdx_t rs1, rs2, rd, rsC, rdC;
	aluOp_e  aluOp;
	cSrc_e   cSrc;
	logic    useImm, writeMain, writeC;
	word_t   imm, immC;

	// register file values and bypassed operands
	word_t   regA, regB, regC;
	word_t   opA, opB, opC;

	////////////////////
	// bundle register
	////////////////////

	// first stage, result register is the second
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validQ  <= 1'b0;
			instrQ  <= '0;
			instrCQ <= '0;
		end
		else
		begin
			validQ  <= bundleValid;
			instrQ  <= instr;
			instrCQ <= instrC;
		end
	end

	////////////////////
	// stages
	////////////////////

	bundleDecoder i_decoder (.valid(validQ), .instr(instrQ), .instrC(instrCQ),
		.rs1(rs1), .rs2(rs2), .rd(rd), .aluOp(aluOp), .useImm(useImm), .imm(imm),
		.writeMain(writeMain), .rsC(rsC), .rdC(rdC), .cSrc(cSrc), .immC(immC),
		.writeC(writeC));

	// result register writes back one edge after it shows
	registerFile i_regFile (.clk(clk), .reset(reset),
		.wrEn(wbWrite), .wrIdx(wbReg), .wrData(wbData),
		.wrEnC(wbWriteC), .wrIdxC(wbRegC), .wrDataC(wbDataC),
		.rdIdxA(rs1), .rdIdxB(rs2), .rdIdxCA(rsC),
		.rdDataA(regA), .rdDataB(regB), .rdDataCA(regC));

	operandForward i_forward (.rs1(rs1), .rs2(rs2), .rsC(rsC),
		.regA(regA), .regB(regB), .regC(regC),
		.fwdWrite(wbWrite), .fwdReg(wbReg), .fwdData(wbData),
		.fwdWriteC(wbWriteC), .fwdRegC(wbRegC), .fwdDataC(wbDataC),
		.opA(opA), .opB(opB), .opC(opC));

	executeSlots i_execute (.clk(clk), .reset(reset), .valid(validQ),
		.aluOp(aluOp), .useImm(useImm), .imm(imm), .rd(rd), .writeMain(writeMain),
		.cSrc(cSrc), .immC(immC), .rdC(rdC), .writeC(writeC),
		.opA(opA), .opB(opB), .opC(opC),
		.resultValid(resultValid), .wbWrite(wbWrite), .wbReg(wbReg), .wbData(wbData),
		.wbWriteC(wbWriteC), .wbRegC(wbRegC), .wbDataC(wbDataC));

	// stream valid must be driven once out of reset
	validKnown: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(bundleValid));

endmodule

/* hw/vliwPkg.sv */
// vliw core shared types
`include "vliw_defines.svh"

package vliwPkg;

	////////////////////
	// vectors
	////////////////////

	// register or result value
	typedef logic [`VLIW_XLEN-1:0] word_t;

	// register index
	typedef logic [`VLIW_REG_IDX_W-1:0] regIdx_t;

	// main slot instruction word
	typedef logic [`VLIW_INSTR_W-1:0] instr_t;

	// compressed slot instruction
	typedef logic [`VLIW_INSTR_C_W-1:0] instrC_t;

	////////////////////
	// operation selects
	////////////////////

	// main alu operation
	typedef enum logic [1:0]
	{
		aluAdd = 2'd0,
		aluAnd = 2'd1,
		aluSra = 2'd2,
		aluOr  = 2'd3
	} aluOp_e;

	// compressed result source
	typedef enum logic
	{
		cSrcMove = 1'b0,
		cSrcImm  = 1'b1
	} cSrc_e;

endpackage

/* hw/vliw_defines.svh */
// vliw core widths and encodings
`ifndef VLIW_DEFINES_SVH
`define VLIW_DEFINES_SVH

////////////////////
// widths
////////////////////

// datapath and register file
`define VLIW_XLEN       32
`define VLIW_NUM_REGS   32
`define VLIW_REG_IDX_W  5

// slot instruction widths
`define VLIW_INSTR_W    32
`define VLIW_INSTR_C_W  16

////////////////////
// main slot encodings
////////////////////

// register-register group, only add is kept
`define VLIW_OP_REG     7'b0110011
// register-immediate group, andi and srai
`define VLIW_OP_IMM     7'b0010011
`define VLIW_F3_ANDI    3'b110
`define VLIW_F3_SRAI    3'b101

////////////////////
// compressed slot quadrants
////////////////////

// c.mv and c.li, quadrant 00 (c.lw) writes nothing
`define VLIW_QUAD_MV    2'b10
`define VLIW_QUAD_LI    2'b01

`endif

/* verification/bundleVectors.txt */
// gap instr instrC | write rd data | writeC rdC dataC, all hex, one bundle per line
// gap before bundle: 0 none, 1 random 0..2, 2 two idle cycles, f ends the table
// reset state, c.mv from untouched x7
1 00000000 829E 0 00 00000000 1 05 00000000
// single-slot results: c.li negative and positive, andi, srai, add
1 00209023 50F5 0 00 00000000 1 01 FFFFFFFD
1 FF00E193 4135 1 03 FFFFFFF0 1 02 0000000D
1 4021D213 0000 1 04 FFFFFFFC 0 00 00000000
1 00410333 838A 1 06 00000009 1 07 0000000D
// back-to-back dependents through the bypass
1 00F36493 4415 1 09 00000009 1 08 00000005
0 00940533 85A6 1 0A 0000000E 1 0B 00000009
0 00A50633 86AE 1 0C 0000001C 1 0D 00000009
// gapped dependents from the register file
2 40165713 87B6 1 0E 0000000E 1 0F 00000009
2 00F70833 0000 1 10 00000017 0 00 00000000
// both slots on one register, compressed value wins
1 7FF16893 58FD 1 11 0000000D 1 11 FFFFFFFF
0 00288933 89C6 1 12 0000000C 1 13 FFFFFFFF
1 00630A33 4A1D 1 14 00000012 1 14 00000007
2 001A0B33 8AD2 1 16 00000004 1 15 00000007
// bge, c.lw, jalr, sh-free zero word, none of them write
1 0020D0E3 4084 0 00 00000000 0 00 00000000
0 000100E7 0000 0 00 00000000 0 00 00000000
0 00000000 4080 0 00 00000000 0 00 00000000
0 00208BB3 8C06 1 17 0000000A 1 18 FFFFFFFD
// immediate extremes and r0 as a normal register
1 41FC5D13 5C81 1 1A FFFFFFFF 1 19 FFFFFFE0
1 800CEE13 4DFD 1 1C FFFFF800 1 1B 0000001F
0 01CD8033 8EEE 1 00 FFFFF81F 1 1D 0000001F
1 40405F93 8F02 1 1F FFFFFF81 1 1E FFFFF81F
// end of table
F 00000000 0000 0 00 00000000 0 00 00000000

/* verification/vliwCore_tb.sv */
// vliw core testbench
module vliwCore_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import vliwPkg::*;

	localparam int ClkPeriod      = 20;
	localparam int ResetCycles    = 4;
	// a table row holds the gap code and eight fields
	localparam int RowWords       = 9;
	localparam int MaxRows        = 64;
	// bundles in flight between drive and check
	localparam int PipeDepth      = 2;
	localparam int WatchdogCycles = 2000;
	localparam int Seed           = 86;

	// expected writeback of one cycle with valid low when idle
	typedef struct packed
	{
		logic    valid;
		logic    write;
		regIdx_t idx;
		word_t   data;
		logic    writeC;
		regIdx_t idxC;
		word_t   dataC;
		int      row;
	} expect_t;

	logic    clk;
	logic    reset;
	logic    bundleValid;
	instr_t  instr;
	instrC_t instrC;
	logic    resultValid;
	logic    wbWrite;
	regIdx_t wbReg;
	word_t   wbData;
	logic    wbWriteC;
	regIdx_t wbRegC;
	word_t   wbDataC;

	// flat copy of the vector table
	logic [31:0] vecMem [MaxRows*RowWords];

	// results in flight with the oldest first
	expect_t pending[$];
	expect_t idleExpect;

	vliwCore i_dut (.clk(clk), .reset(reset), .bundleValid(bundleValid),
		.instr(instr), .instrC(instrC), .resultValid(resultValid),
		.wbWrite(wbWrite), .wbReg(wbReg), .wbData(wbData),
		.wbWriteC(wbWriteC), .wbRegC(wbRegC), .wbDataC(wbDataC));

	initial
	begin
		clk = 1'b0;
		forever #(ClkPeriod/2) clk = ~clk;
	end

	////////////////////
	// reporting
	////////////////////

	task automatic abortRun(input string why);
		$display("ERROR at %0d ns: %s", $time, why);
		$display("TEST FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic reportMismatch(input string what);
		$display("MISMATCH at %0d ns: %s", $time, what);
		$display("TEST FAILED");
		$fatal(1, "run stopped at first mismatch");
	endtask

	////////////////////
	// checking
	////////////////////

	// slot index and data only matter when the slot writes
	task automatic checkOutputs(input expect_t e);
		assert (resultValid === e.valid)
		else
			reportMismatch($sformatf("row %0d resultValid %b, expected %b",
				e.row, resultValid, e.valid));
		assert (wbWrite === e.write)
		else
			reportMismatch($sformatf("row %0d wbWrite %b, expected %b",
				e.row, wbWrite, e.write));
		assert (wbWriteC === e.writeC)
		else
			reportMismatch($sformatf("row %0d wbWriteC %b, expected %b",
				e.row, wbWriteC, e.writeC));
		if (e.write)
		begin
			assert ((wbReg === e.idx) && (wbData === e.data))
			else
				reportMismatch($sformatf("row %0d main x%0d=%h, expected x%0d=%h",
					e.row, wbReg, wbData, e.idx, e.data));
		end
		if (e.writeC)
		begin
			assert ((wbRegC === e.idxC) && (wbDataC === e.dataC))
			else
				reportMismatch($sformatf("row %0d compressed x%0d=%h, expected x%0d=%h",
					e.row, wbRegC, wbDataC, e.idxC, e.dataC));
		end
	endtask

	// expected writeback of one table row
	function automatic expect_t rowExpect(input int r);
		expect_t e;
		int      base;
		base     = r * RowWords;
		e.valid  = 1'b1;
		e.write  = vecMem[base+3][0];
		e.idx    = vecMem[base+4][4:0];
		e.data   = vecMem[base+5];
		e.writeC = vecMem[base+6][0];
		e.idxC   = vecMem[base+7][4:0];
		e.dataC  = vecMem[base+8];
		e.row    = r;
		return e;
	endfunction

	// check the bundle driven two cycles ago and then drive the next one
	task automatic stepCycle(input logic v, input instr_t i, input instrC_t c,
		input expect_t e);
		@(negedge clk);
		checkOutputs(pending.pop_front());
		bundleValid = v;
		instr       = i;
		instrC      = c;
		pending.push_back(e);
	endtask

	////////////////////
	// stimulus
	////////////////////

	initial
	begin
		int   row;
		int   ctrl;
		int   gap;
		logic tableEnd;

		void'($urandom(Seed));
		reset          = 1'b1;
		bundleValid    = 1'b0;
		instr          = '0;
		instrC         = '0;
		idleExpect     = '0;
		idleExpect.row = -1;

		// unused words hold no legal gap code
		for (int i = 0; i < MaxRows*RowWords; i++)
		begin
			vecMem[i] = ~i;
		end
		$readmemh("verification/bundleVectors.txt", vecMem);

		for (int c = 0; c < ResetCycles; c++)
		begin
			@(posedge clk);
		end
		@(negedge clk);
		reset = 1'b0;
		// outputs idle straight out of reset
		checkOutputs(idleExpect);
		for (int p = 0; p < PipeDepth; p++)
		begin
			pending.push_back(idleExpect);
		end

		row      = 0;
		tableEnd = 1'b0;
		while (!tableEnd && (row < MaxRows))
		begin
			ctrl = int'(vecMem[row*RowWords]);
			if (ctrl == 'hF)
			begin
				tableEnd = 1'b1;
			end
			else
			begin
				assert ((ctrl >= 0) && (ctrl <= 2))
				else
					abortRun($sformatf("vector row %0d has an unknown gap code", row));
				case (ctrl)
					0: gap = 0;
					2: gap = 2;
					default: gap = int'($urandom_range(2, 0));
				endcase
				for (int g = 0; g < gap; g++)
				begin
					stepCycle(1'b0, '0, '0, idleExpect);
				end
				stepCycle(1'b1, vecMem[row*RowWords+1], vecMem[row*RowWords+2][15:0],
					rowExpect(row));
				row++;
			end
		end

		if (!tableEnd)
		begin
			abortRun("vector table has no end marker");
		end
		else
		begin
			// let the last two bundles come out
			for (int d = 0; d < PipeDepth; d++)
			begin
				stepCycle(1'b0, '0, '0, idleExpect);
			end
			$display("TEST PASSED");
			$finish;
		end
	end

	// hang guard
	initial
	begin
		for (int w = 0; w < WatchdogCycles; w++)
		begin
			@(posedge clk);
		end
		abortRun($sformatf("run did not finish within %0d cycles", WatchdogCycles));
	end

endmodule

/* vliwCore.f */
+incdir+hw
hw/vliwPkg.sv
hw/registerFile.sv
hw/bundleDecoder.sv
hw/operandForward.sv
hw/executeSlots.sv
hw/vliwCore.sv
verification/vliwCore_tb.sv
